// File: include/cr16_defs.svh
// Word width, register count and register index width macros
`ifndef CR16_DEFS_SVH
`define CR16_DEFS_SVH

// Datapath word, two's complement
`define WORD_WIDTH 16

// General purpose registers r0 to r15
`define REG_COUNT 16

// Index width for REG_COUNT registers
`define REG_ADDR_WIDTH 4

`endif

// File: project.f
+incdir+include
rtl/cr16IsaPkg.sv
rtl/cr16DpPkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/shifter.sv
rtl/execControl.sv
rtl/execCore.sv
verif/execCoreTb.sv

// File: rtl/alu.sv
// Adder/subtractor and logic unit with carry, low, overflow, zero, negative
`timescale 1ns/10ps
`include "cr16_defs.svh"

module alu
	import cr16DpPkg::*;
(
	input  logic [`WORD_WIDTH-1:0] regSrc,      // Second operand, register or immediate
	input  logic [`WORD_WIDTH-1:0] regDst,      // Rdest
	input  aluOpT                  aluOp,
	output logic [`WORD_WIDTH-1:0] aluResult,
	output logic                   aluCarry,
	output logic                   aluLow,
	output logic                   aluOverflow,
	output logic                   aluZero,
	output logic                   aluNegative
);

	logic [`WORD_WIDTH-1:0] regSrc2;  // Inverted for subtract
	logic [`WORD_WIDTH:0]   sumFull;  // Extra bit is the carry out
	logic [`WORD_WIDTH-1:0] sum;
	logic                   carryOut;

	// Rdest + Rsrc, or Rdest + ~Rsrc + 1
	assign regSrc2  = aluOp[2] ? ~regSrc : regSrc;
	assign sumFull  = {1'b0, regDst} + {1'b0, regSrc2} + {{`WORD_WIDTH{1'b0}}, aluOp[2]};
	assign sum      = sumFull[`WORD_WIDTH-1:0];
	assign carryOut = sumFull[`WORD_WIDTH];

	// No carry out on subtract means a borrow
	assign aluCarry = aluOp[2] ? ~carryOut : carryOut;

	// Same operand signs with a flipped result sign
	assign aluOverflow = (regDst[`WORD_WIDTH-1] == regSrc2[`WORD_WIDTH-1]) &&
		(sum[`WORD_WIDTH-1] != regDst[`WORD_WIDTH-1]);

	// Compare flags, Rdest against Rsrc
	assign aluLow      = regDst < regSrc;                   // Unsigned
	assign aluZero     = regDst == regSrc;
	assign aluNegative = $signed(regDst) < $signed(regSrc); // Signed

	always_comb begin
		case (aluOp[1:0])
			2'b00:   aluResult = sum;              // Add or subtract
			2'b01:   aluResult = regDst & regSrc;
			2'b10:   aluResult = regDst | regSrc;
			default: aluResult = regDst ^ regSrc;
		endcase
	end

endmodule

// File: rtl/cr16DpPkg.sv
// Datapath control types: ALU operation, result source, flag-update class
package cr16DpPkg;

	// Bit 2 selects subtract, bits 1:0 select the result
	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_AND = 3'b001,
		ALU_OR  = 3'b010,
		ALU_XOR = 3'b011,
		ALU_SUB = 3'b100
	} aluOpT;

	// Where the writeback value comes from
	typedef enum logic [1:0] {
		RES_ALU   = 2'b00,
		RES_SHIFT = 2'b01,
		RES_OPB   = 2'b10, // MOV and MOVI
		RES_LUI   = 2'b11
	} resultSrcT;

	// Which status flags an instruction touches
	typedef enum logic [1:0] {
		FLAG_NONE  = 2'b00,
		FLAG_ARITH = 2'b01, // Carry and overflow
		FLAG_CMP   = 2'b10  // Low, zero and negative
	} flagUpdT;

endpackage

// File: rtl/cr16IsaPkg.sv
// Instruction encoding: opcode and extension enumerations, field positions
package cr16IsaPkg;

	// Major opcode in instr[15:12]
	typedef enum logic [3:0] {
		OP_REG   = 4'b0000, // Register forms, operation in ext field
		OP_ANDI  = 4'b0001,
		OP_ORI   = 4'b0010,
		OP_XORI  = 4'b0011,
		OP_ADDI  = 4'b0101,
		OP_SHIFT = 4'b1000, // LSH and LSHI
		OP_SUBI  = 4'b1001,
		OP_CMPI  = 4'b1011,
		OP_MOVI  = 4'b1101,
		OP_LUI   = 4'b1111
	} opcodeT;

	// Extension in instr[7:4]
	typedef enum logic [3:0] {
		EXT_LSHI = 4'b0000, // Bit 4 is also the count sign, so 0001 is LSHI too
		EXT_AND  = 4'b0001,
		EXT_OR   = 4'b0010,
		EXT_XOR  = 4'b0011,
		EXT_LSH  = 4'b0100,
		EXT_ADD  = 4'b0101,
		EXT_SUB  = 4'b1001,
		EXT_CMP  = 4'b1011,
		EXT_MOV  = 4'b1101
	} extT;

	// Field positions
	localparam int unsigned OP_MSB       = 15;
	localparam int unsigned OP_LSB       = 12;
	localparam int unsigned DST_MSB      = 11; // Rdest
	localparam int unsigned DST_LSB      = 8;
	localparam int unsigned EXT_MSB      = 7;
	localparam int unsigned EXT_LSB      = 4;
	localparam int unsigned SRC_MSB      = 3;  // Rsrc, also low bits of LSHI count
	localparam int unsigned SRC_LSB      = 0;
	localparam int unsigned IMM_MSB      = 7;
	localparam int unsigned IMM_LSB      = 0;
	localparam int unsigned CNT_SIGN_BIT = 4;  // LSHI count sign
	localparam int unsigned IMM_WIDTH    = IMM_MSB - IMM_LSB + 1;

endpackage

// File: rtl/execControl.sv
// Execute control with decode, operand select, status register and writeback
`timescale 1ns/10ps
`include "cr16_defs.svh"

module execControl
	import cr16IsaPkg::*;
	import cr16DpPkg::*;
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       instrValid,  // One cycle strobe
	input  logic [15:0]                instr,
	input  logic [`WORD_WIDTH-1:0]     srcData,     // Rsrc
	input  logic [`WORD_WIDTH-1:0]     dstData,     // Rdest
	input  logic [`WORD_WIDTH-1:0]     aluResult,
	input  logic                       aluCarry,
	input  logic                       aluLow,
	input  logic                       aluOverflow,
	input  logic                       aluZero,
	input  logic                       aluNegative,
	input  logic [`WORD_WIDTH-1:0]     shiftResult,
	output logic [`REG_ADDR_WIDTH-1:0] srcAddr,
	output logic [`REG_ADDR_WIDTH-1:0] dstAddr,
	output logic [`WORD_WIDTH-1:0]     opB,         // Second ALU operand
	output aluOpT                      aluOp,
	output logic [4:0]                 shiftCount,  // Signed
	output logic                       wrEn,
	output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	output logic [`WORD_WIDTH-1:0]     wrData,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`WORD_WIDTH-1:0]     wbData,
	output logic                       carry,
	output logic                       low,
	output logic                       overflow,
	output logic                       zero,
	output logic                       negative
);

	opcodeT                  opcode;
	extT                     ext;
	logic [IMM_WIDTH-1:0]    imm;
	logic [`WORD_WIDTH-1:0]  immSext, immZext, luiValue;
	logic                    known;      // Encoding is in the table
	logic                    useImm;     // opB from immediate
	logic                    immSigned;
	logic                    countImm;   // LSHI count from instruction
	resultSrcT               resultSrc;
	flagUpdT                 flagUpd;
	logic [`WORD_WIDTH-1:0]  result;

	// Field extraction
	assign opcode  = opcodeT'(instr[OP_MSB:OP_LSB]);
	assign ext     = extT'(instr[EXT_MSB:EXT_LSB]);
	assign dstAddr = instr[DST_MSB:DST_LSB];
	assign srcAddr = instr[SRC_MSB:SRC_LSB];
	assign imm     = instr[IMM_MSB:IMM_LSB];

	assign immSext  = {{(`WORD_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
	assign immZext  = {{(`WORD_WIDTH-IMM_WIDTH){1'b0}}, imm};
	assign luiValue = {imm, {(`WORD_WIDTH-IMM_WIDTH){1'b0}}}; // Immediate to high byte

	// Decode
	always_comb begin
		known     = 1'b1;
		aluOp     = ALU_ADD;
		resultSrc = RES_ALU;
		flagUpd   = FLAG_NONE;
		useImm    = 1'b0;
		immSigned = 1'b0;
		countImm  = 1'b0;
		case (opcode)
			OP_REG: begin
				case (ext)
					EXT_AND: aluOp = ALU_AND;
					EXT_OR:  aluOp = ALU_OR;
					EXT_XOR: aluOp = ALU_XOR;
					EXT_ADD: begin
						aluOp   = ALU_ADD;
						flagUpd = FLAG_ARITH;
					end
					EXT_SUB: begin
						aluOp   = ALU_SUB;
						flagUpd = FLAG_ARITH;
					end
					EXT_CMP: begin
						aluOp   = ALU_SUB; // Compare as Rdest - Rsrc
						flagUpd = FLAG_CMP;
					end
					EXT_MOV: resultSrc = RES_OPB;
					default: known = 1'b0;
				endcase
			end
			OP_ANDI: begin
				aluOp  = ALU_AND;
				useImm = 1'b1;
			end
			OP_ORI: begin
				aluOp  = ALU_OR;
				useImm = 1'b1;
			end
			OP_XORI: begin
				aluOp  = ALU_XOR;
				useImm = 1'b1;
			end
			OP_ADDI: begin
				aluOp     = ALU_ADD;
				flagUpd   = FLAG_ARITH;
				useImm    = 1'b1;
				immSigned = 1'b1;
			end
			OP_SUBI: begin
				aluOp     = ALU_SUB;
				flagUpd   = FLAG_ARITH;
				useImm    = 1'b1;
				immSigned = 1'b1;
			end
			OP_CMPI: begin
				aluOp     = ALU_SUB;
				flagUpd   = FLAG_CMP;
				useImm    = 1'b1;
				immSigned = 1'b1;
			end
			OP_MOVI: begin
				resultSrc = RES_OPB;
				useImm    = 1'b1;
			end
			OP_LUI: resultSrc = RES_LUI;
			OP_SHIFT: begin
				resultSrc = RES_SHIFT;
				if (ext == EXT_LSH)
					countImm = 1'b0;  // Count from Rsrc
				else if ({ext[3:1], 1'b0} == EXT_LSHI)
					countImm = 1'b1;  // Bit 4 is the count sign
				else
					known = 1'b0;
			end
			default: known = 1'b0;
		endcase
	end

	// Operands
	assign opB        = useImm ? (immSigned ? immSext : immZext) : srcData;
	assign shiftCount = countImm ? {instr[CNT_SIGN_BIT], instr[SRC_MSB:SRC_LSB]} : srcData[4:0];

	always_comb begin
		case (resultSrc)
			RES_ALU:   result = aluResult;
			RES_SHIFT: result = shiftResult;
			RES_OPB:   result = opB;
			default:   result = luiValue;
		endcase
	end

	// Register file write lands at the edge ending the strobe cycle
	assign wrEn   = instrValid && known && (flagUpd != FLAG_CMP); // Compares never write
	assign wrAddr = dstAddr;
	assign wrData = result;

	// Writeback outputs and status register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid  <= 1'b0;
			wbReg    <= '0;
			wbData   <= '0;
			carry    <= 1'b0;
			low      <= 1'b0;
			overflow <= 1'b0;
			zero     <= 1'b0;
			negative <= 1'b0;
		end else begin
			wbValid <= wrEn; // High for one cycle only
			if (wrEn) begin
				wbReg  <= wrAddr;
				wbData <= wrData;
			end
			if (instrValid && known) begin
				case (flagUpd)
					FLAG_ARITH: begin
						carry    <= aluCarry;    // Carry out or borrow
						overflow <= aluOverflow;
					end
					FLAG_CMP: begin
						low      <= aluLow;
						zero     <= aluZero;
						negative <= aluNegative;
					end
					default: ; // Flags hold
				endcase
			end
		end
	end

endmodule

// File: rtl/execCore.sv
// Execute stage top: control, register file, ALU and shifter
`timescale 1ns/10ps
`include "cr16_defs.svh"

module execCore
	import cr16DpPkg::*;
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       instrValid,
	input  logic [15:0]                instr,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`WORD_WIDTH-1:0]     wbData,
	output logic                       carry,
	output logic                       low,
	output logic                       overflow,
	output logic                       zero,
	output logic                       negative
);

	// Register file ports
	logic [`REG_ADDR_WIDTH-1:0] srcAddr, dstAddr, wrAddr;
	logic [`WORD_WIDTH-1:0]     srcData, dstData, wrData;
	logic                       wrEn;

	// ALU and shifter
	logic [`WORD_WIDTH-1:0] opB, aluResult, shiftResult;
	aluOpT                  aluOp;
	logic [4:0]             shiftCount;
	logic                   aluCarry, aluLow, aluOverflow, aluZero, aluNegative;

	execControl i_control (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.instr       (instr),
		.srcData     (srcData),
		.dstData     (dstData),
		.aluResult   (aluResult),
		.aluCarry    (aluCarry),
		.aluLow      (aluLow),
		.aluOverflow (aluOverflow),
		.aluZero     (aluZero),
		.aluNegative (aluNegative),
		.shiftResult (shiftResult),
		.srcAddr     (srcAddr),
		.dstAddr     (dstAddr),
		.opB         (opB),
		.aluOp       (aluOp),
		.shiftCount  (shiftCount),
		.wrEn        (wrEn),
		.wrAddr      (wrAddr),
		.wrData      (wrData),
		.wbValid     (wbValid),
		.wbReg       (wbReg),
		.wbData      (wbData),
		.carry       (carry),
		.low         (low),
		.overflow    (overflow),
		.zero        (zero),
		.negative    (negative)
	);

	regFile i_regFile (
		.clk     (clk),
		.rstN    (rstN),
		.srcAddr (srcAddr),
		.dstAddr (dstAddr),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.srcData (srcData),
		.dstData (dstData)
	);

	// Rdest is always the first operand
	alu i_alu (
		.regSrc      (opB),
		.regDst      (dstData),
		.aluOp       (aluOp),
		.aluResult   (aluResult),
		.aluCarry    (aluCarry),
		.aluLow      (aluLow),
		.aluOverflow (aluOverflow),
		.aluZero     (aluZero),
		.aluNegative (aluNegative)
	);

	shifter i_shifter (
		.value       (dstData),
		.shiftCount  (shiftCount),
		.shiftResult (shiftResult)
	);

endmodule

// File: rtl/regFile.sv
// Sixteen-word register file, two combinational reads, one clocked write
`timescale 1ns/10ps
`include "cr16_defs.svh"

module regFile (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`REG_ADDR_WIDTH-1:0] srcAddr,
	input  logic [`REG_ADDR_WIDTH-1:0] dstAddr,
	input  logic                       wrEn,
	input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`WORD_WIDTH-1:0]     wrData,
	output logic [`WORD_WIDTH-1:0]     srcData,
	output logic [`WORD_WIDTH-1:0]     dstData
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT]; // r0 to r15

	// Write port, all registers cleared on reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Read ports without a clock
	assign srcData = regs[srcAddr];
	assign dstData = regs[dstAddr];

endmodule

// File: rtl/shifter.sv
// Logical shifter, direction and amount from a signed five-bit count
`timescale 1ns/10ps
`include "cr16_defs.svh"

module shifter (
	input  logic [`WORD_WIDTH-1:0] value,       // Rdest
	input  logic [4:0]             shiftCount,  // -16 to 15
	output logic [`WORD_WIDTH-1:0] shiftResult
);

	logic [4:0] magnitude; // Right shift amount, up to 16

	// Two's complement negate of the count
	assign magnitude = ~shiftCount + 5'd1;

	always_comb begin
		if (shiftCount[4]) begin
			// Negative count shifts right, zeros in at the top
			shiftResult = value >> magnitude; // 16 clears the word
		end else begin
			shiftResult = value << shiftCount[3:0];
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f project.f --top-module execCoreTb \
	-Mdir obj_dir -o execCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/execCoreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the testbench output
if grep -q "All tests passed" <<< "$output"; then
	exit 0
fi
exit 1

// File: verif/execCoreTb.sv
// Execute stage testbench with clock, reset, LFSR stimulus, reference model, checker, timeout
`timescale 1ns/10ps
`include "cr16_defs.svh"

module execCoreTb;

	localparam int RESET_CYCLES = 10;
	localparam int N_ARITH = 40, N_CMP = 20, N_LOGIC = 30, N_SHIFT = 16;
	localparam int N_CHAIN = 8, N_RAND = 60;
	// MOVI, LUI/ORI fill, arith, compares, logic, LSHI, LSH pairs, chain, random, unlisted
	localparam int STROBES = 16 + 32 + N_ARITH + N_CMP + 2 + N_LOGIC + 32 + 2 * N_SHIFT
		+ N_CHAIN + N_RAND + 3;
	localparam int MAX_GAPS = 3 * N_RAND + 3;
	localparam int TIMEOUT_CYCLES = 2 * (STROBES + MAX_GAPS + RESET_CYCLES);

	logic clk = 1'b0;
	logic rstN, instrValid;
	logic [15:0] instr;
	logic wbValid, carry, low, overflow, zero, negative;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`WORD_WIDTH-1:0] wbData;

	logic [`WORD_WIDTH-1:0] refRegs [`REG_COUNT]; // Model register file
	logic [4:0] refFlags = '0;                    // Carry, low, overflow, zero, negative
	logic expWb = 1'b0;
	logic [3:0] expReg;
	logic [15:0] expData;
	logic [31:0] lfsr = 32'd78118;
	int errors = 0, checks = 0, cycles = 0;
	logic [3:0] rd, rs;
	logic [7:0] imm;
	logic [4:0] cnt;

	execCore i_dut (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .carry(carry),
		.low(low), .overflow(overflow), .zero(zero), .negative(negative)
	);

	always #2 clk = ~clk; // 4 ns period

	// Galois step with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// Reference model that returns {writeback, reg, data} and updates model state
	function automatic logic [20:0] predict(input logic [15:0] ins);
		logic [3:0] op, ext, dst, fn;
		logic [15:0] a, b, res;
		logic [16:0] sum;
		logic [4:0] fl, sc;
		logic known, wr;
		int c;
		int s;
		op = ins[15:12];
		ext = ins[7:4];
		dst = ins[11:8];
		a = refRegs[dst];
		fl = refFlags;
		known = 1'b1;
		wr = 1'b1;
		res = '0;
		if (op == 4'h5 || op == 4'h9 || op == 4'hB)
			b = {{8{ins[7]}}, ins[7:0]};   // Signed immediate
		else if (op != 4'h0 && op != 4'h8)
			b = {8'h00, ins[7:0]};         // Unsigned immediate
		else
			b = refRegs[ins[3:0]];
		if (op == 4'h8) begin
			known = (ext == 4'h4) || (ext[3:1] == 3'b000);
			sc = (ext == 4'h4) ? b[4:0] : {ins[4], ins[3:0]};
			c = int'($signed(sc));
			res = (c >= 0) ? (a << c) : (a >> (-c)); // Negative count is a right shift
		end else begin
			fn = (op == 4'h0) ? ext : op;  // Immediate opcodes match register extensions
			if (op == 4'h0 && fn == 4'hF)
				known = 1'b0;
			case (fn)
				4'h1: res = a & b;
				4'h2: res = a | b;
				4'h3: res = a ^ b;
				4'h5: begin
					sum = {1'b0, a} + {1'b0, b};
					res = sum[15:0];
					fl[4] = sum[16];
					s = int'($signed(a)) + int'($signed(b));
					fl[2] = (s > 32767) || (s < -32768); // Signed sum out of range
				end
				4'h9: begin
					res = a - b;
					fl[4] = a < b; // Borrow
					s = int'($signed(a)) - int'($signed(b));
					fl[2] = (s > 32767) || (s < -32768);
				end
				4'hB: begin
					wr = 1'b0;
					fl[3] = a < b;
					fl[1] = a == b;
					fl[0] = $signed(a) < $signed(b);
				end
				4'hD: res = b;
				4'hF: res = {ins[7:0], 8'h00}; // LUI
				default: known = 1'b0;
			endcase
		end
		if (known && wr)
			refRegs[dst] = res;
		if (known)
			refFlags = fl;
		return {known && wr, dst, res};
	endfunction

	task automatic compareValue(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Strobes for one cycle and idles for gap cycles
	task automatic issue(input logic [15:0] ins, input int gap);
		instr <= ins;
		instrValid <= 1'b1;
		@(posedge clk);
		instrValid <= 1'b0;
		repeat (gap) @(posedge clk);
	endtask

	// Compares the cycle after each strobe and then models the strobe of this cycle
	always @(negedge clk) begin
		if (rstN) begin
			if (wbValid !== expWb) begin
				errors++;
				if (expWb)
					$display("Writeback missing at %0d ns", $time);
				else
					$display("Unexpected writeback at %0d ns", $time);
			end else if (expWb) begin
				compareValue(16'(wbReg), 16'(expReg), "wbReg");
				compareValue(wbData, expData, "wbData");
			end
			compareValue(16'({carry, low, overflow, zero, negative}), 16'(refFlags), "flags");
			if (instrValid)
				{expWb, expReg, expData} = predict(instr);
			else
				expWb = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		for (int i = 0; i < `REG_COUNT; i++)
			refRegs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		repeat (2) @(posedge clk); // First checks see reset values

		for (int r = 0; r < 16; r++)
			issue({4'hD, 4'(r), 8'(randBits(8))}, 0); // MOVI to each register
		for (int r = 0; r < 16; r++) begin
			issue({4'hF, 4'(r), 8'(randBits(8))}, 0); // Full words from LUI then ORI
			issue({4'h2, 4'(r), 8'(randBits(8))}, 0);
		end

		for (int i = 0; i < N_ARITH; i++) begin
			rd = 4'(randBits(4));
			rs = 4'(randBits(4));
			imm = 8'(randBits(8));
			case (2'(randBits(2)))
				2'd0: issue({4'h0, rd, 4'h5, rs}, 0); // ADD
				2'd1: issue({4'h5, rd, imm}, 0);      // ADDI
				2'd2: issue({4'h0, rd, 4'h9, rs}, 0); // SUB
				default: issue({4'h9, rd, imm}, 0);   // SUBI
			endcase
		end

		issue({4'hD, 4'h1, 8'h05}, 0);  // Equal operands through CMPI
		issue({4'hB, 4'h1, 8'h05}, 1);
		for (int i = 0; i < N_CMP; i++) begin
			rd = 4'(randBits(4));
			rs = (randBits(2) == 0) ? rd : 4'(randBits(4));
			if (randBits(1) == 0)
				issue({4'h0, rd, 4'hB, rs}, 0);
			else
				issue({4'hB, rd, 8'(randBits(8))}, 0);
		end

		for (int i = 0; i < N_LOGIC; i++) begin
			rd = 4'(randBits(4));
			rs = 4'(randBits(4));
			imm = 8'(randBits(8));
			case (3'(randBits(3)))
				3'd0: issue({4'h0, rd, 4'h1, rs}, 0);
				3'd1: issue({4'h0, rd, 4'h2, rs}, 0);
				3'd2: issue({4'h0, rd, 4'h3, rs}, 0);
				3'd3: issue({4'h1, rd, imm}, 0);
				3'd4: issue({4'h2, rd, imm}, 0);
				3'd5: issue({4'h3, rd, imm}, 0);
				3'd6: issue({4'h0, rd, 4'hD, rs}, 0); // MOV
				default: issue({4'hF, rd, imm}, 0);
			endcase
		end

		for (int c = 0; c < 32; c++)
			issue({4'h8, 4'(randBits(4)), 3'b000, 5'(c)}, 0); // Every LSHI count
		for (int i = 0; i < N_SHIFT; i++) begin
			cnt = (i == 0) ? 5'b10000 : ((i == 1) ? 5'd0 : 5'(randBits(5)));
			rs = 4'(randBits(4));
			issue({4'hD, rs, 3'(randBits(3)), cnt}, 0);      // Count into Rsrc
			issue({4'h8, 4'(randBits(4)), 4'h4, rs}, 0);     // LSH
		end

		for (int i = 0; i < N_CHAIN; i++)
			issue({4'h5, 4'h3, 8'(randBits(8))}, 0); // Each ADDI builds on the last
		issue({4'h4, 12'(randBits(12))}, 0);      // Unlisted opcode
		issue({4'h0, 4'h2, 4'h7, 4'h3}, 0);       // Unlisted extension
		issue({4'h8, 4'h2, 4'hC, 4'h3}, 0);       // Unlisted shift form
		for (int i = 0; i < N_RAND; i++)
			issue(randBits(16), int'(randBits(2)));

		repeat (3) @(posedge clk);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
